// File: common/eeprom_pkg.sv
// shared types for the two-wire EEPROM controller
package eeprom_pkg;

    // 11-bit byte address, top three bits go in the control byte
    typedef logic [10:0] eeprom_addr_t;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // direction bit at the end of the control byte
    localparam logic DIR_WR = 1'b0;
    localparam logic DIR_RD = 1'b1;

    typedef enum logic [1:0] {
        CMD_START = 2'd0,  // also repeated start when scl is low
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,  // 8 bits out, 9th clock with sda released
        CMD_READ  = 2'd3   // 8 bits in, nack on the 9th clock
    } bus_cmd_e;

    // sequencer to bus engine request
    typedef struct packed {
        bus_cmd_e   cmd;
        logic [7:0] wr_byte;
    } bus_req_t;

    // control byte: device code, page bits, direction
    function automatic logic [7:0] ctrl_byte(input eeprom_addr_t addr, input logic dir);
        return {DEVICE_CODE, addr[10:8], dir};
    endfunction

endpackage

// File: rtl/eeprom_sequencer.sv
`timescale 1ns/1ns
module eeprom_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  logic [7:0]              wr_data,
    input  logic                    req_done,
    input  logic [7:0]              rx_byte,
    output logic                    req_valid,
    output eeprom_pkg::bus_req_t    req,
    output logic [7:0]              rd_data,
    output logic                    ack,
    output logic                    busy
);
    import eeprom_pkg::*;

    // one-hot main states
    typedef enum logic [9:0] {
        ST_IDLE    = 10'b00_0000_0001,
        ST_START   = 10'b00_0000_0010,
        ST_CTRL_WR = 10'b00_0000_0100,
        ST_ADDR    = 10'b00_0000_1000,
        ST_DATA_WR = 10'b00_0001_0000,
        ST_RSTART  = 10'b00_0010_0000,
        ST_CTRL_RD = 10'b00_0100_0000,
        ST_DATA_RD = 10'b00_1000_0000,
        ST_STOP    = 10'b01_0000_0000,
        ST_ACKN    = 10'b10_0000_0000
    } seq_state_e;

    seq_state_e   state;
    eeprom_addr_t addr_q;
    logic [7:0]   data_q;
    logic         is_read;
    logic         start_op;

    // ack cycle also takes a new strobe
    assign start_op = (state == ST_IDLE || state == ST_ACKN) && (wr || rd);
    assign ack      = (state == ST_ACKN);
    assign busy     = !(state == ST_IDLE || state == ST_ACKN);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            req_valid <= 1'b0;
            is_read   <= 1'b0;
            rd_data   <= 8'h00;
        end
        else
        begin
            req_valid <= 1'b0;
            case (state)
                ST_IDLE, ST_ACKN:
                    if (start_op)
                    begin
                        is_read   <= !wr; // wr wins
                        req_valid <= 1'b1;
                        state     <= ST_START;
                    end
                    else
                        state <= ST_IDLE;
                ST_START:
                    if (req_done)
                    begin
                        req_valid <= 1'b1;
                        state     <= ST_CTRL_WR;
                    end
                ST_CTRL_WR:
                    if (req_done)
                    begin
                        req_valid <= 1'b1;
                        state     <= ST_ADDR;
                    end
                ST_ADDR:
                    if (req_done)
                    begin
                        req_valid <= 1'b1;
                        state     <= is_read ? ST_RSTART : ST_DATA_WR;
                    end
                ST_DATA_WR, ST_DATA_RD:
                    if (req_done)
                    begin
                        req_valid <= 1'b1;
                        state     <= ST_STOP;
                    end
                ST_RSTART:
                    if (req_done)
                    begin
                        req_valid <= 1'b1;
                        state     <= ST_CTRL_RD;
                    end
                ST_CTRL_RD:
                    if (req_done)
                    begin
                        req_valid <= 1'b1;
                        state     <= ST_DATA_RD;
                    end
                ST_STOP:
                    if (req_done)
                    begin
                        if (is_read)
                            rd_data <= rx_byte;
                        state <= ST_ACKN;
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // address and data taken at the strobe
    always_ff @(posedge CLK)
    begin
        if (start_op)
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

    // bus request for the current state
    always_comb
    begin
        req.cmd     = CMD_WRITE;
        req.wr_byte = 8'h00;
        case (state)
            ST_START, ST_RSTART: req.cmd = CMD_START;
            ST_CTRL_WR:          req.wr_byte = ctrl_byte(addr_q, DIR_WR);
            ST_ADDR:             req.wr_byte = addr_q[7:0];
            ST_DATA_WR:          req.wr_byte = data_q;
            ST_CTRL_RD:          req.wr_byte = ctrl_byte(addr_q, DIR_RD);
            ST_DATA_RD:          req.cmd = CMD_READ;
            default:             req.cmd = CMD_STOP;
        endcase
    end

endmodule

// File: rtl/eeprom_top.sv
`timescale 1ns/1ns
module eeprom_top #(
    parameter int CLK_DIV = 4  // clk cycles per scl half period
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  logic [7:0]              wr_data,
    output logic [7:0]              rd_data,
    output logic                    ack,
    output logic                    busy,
    output logic                    scl,
    output logic                    sda_low,
    input  logic                    sda_in
);
    import eeprom_pkg::*;

    logic       req_valid;
    bus_req_t   req;
    logic       req_done;
    logic [7:0] rx_byte;

    eeprom_sequencer seq0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .req_done  (req_done),
        .rx_byte   (rx_byte),
        .req_valid (req_valid),
        .req       (req),
        .rd_data   (rd_data),
        .ack       (ack),
        .busy      (busy)
    );

    serial_bus_engine #(
        .CLK_DIV (CLK_DIV)
    ) bus0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .sda_in    (sda_in),
        .req_done  (req_done),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_low   (sda_low)
    );

endmodule

// File: run.sh
#!/bin/bash
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module eeprom_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Veeprom_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: serial_bus/serial_bus_engine.sv
`timescale 1ns/1ns
module serial_bus_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req_valid,
    input  eeprom_pkg::bus_req_t req,
    input  logic                sda_in,
    output logic                req_done,
    output logic [7:0]          rx_byte,
    output logic                scl,
    output logic                sda_low
);
    import eeprom_pkg::*;

    localparam int CNT_W = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(CLK_DIV / 2);

    typedef enum logic [1:0] {
        E_IDLE,
        E_START,
        E_STOP,
        E_BYTE
    } eng_state_e;

    eng_state_e state;

    logic [CNT_W-1:0] cnt;      // clk count inside one phase
    logic [1:0]       step;     // phase index for start and stop
    logic             half;     // 0 = scl low half, 1 = scl high half
    logic [3:0]       bit_cnt;  // 0..8, bit 8 is the ack clock
    logic             is_rd;
    logic [7:0]       shreg;

    logic tick;
    logic sample;

    assign tick   = (cnt == CNT_LAST);
    assign sample = half && (cnt == CNT_MID); // middle of scl high

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= E_IDLE;
            cnt      <= '0;
            step     <= 2'd0;
            half     <= 1'b0;
            bit_cnt  <= 4'd0;
            is_rd    <= 1'b0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            req_done <= 1'b0;
        end
        else
        begin
            req_done <= 1'b0;

            if (state == E_IDLE || tick)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            case (state)
                E_IDLE:
                    if (req_valid)
                    begin
                        step    <= 2'd0;
                        half    <= 1'b0;
                        bit_cnt <= 4'd0;
                        is_rd   <= (req.cmd == CMD_READ);
                        case (req.cmd)
                            CMD_START:
                            begin
                                scl     <= 1'b0; // sda released, scl low
                                sda_low <= 1'b0;
                                state   <= E_START;
                            end
                            CMD_STOP:
                            begin
                                scl     <= 1'b0;
                                sda_low <= 1'b1;
                                state   <= E_STOP;
                            end
                            default:
                                state <= E_BYTE;
                        endcase
                    end

                E_START:
                    if (tick)
                    begin
                        step <= step + 2'd1;
                        case (step)
                            2'd0: scl <= 1'b1;
                            2'd1: sda_low <= 1'b1; // start condition
                            2'd2: scl <= 1'b0;
                            default:
                            begin
                                req_done <= 1'b1;
                                state    <= E_IDLE;
                            end
                        endcase
                    end

                E_STOP:
                    if (tick)
                    begin
                        step <= step + 2'd1;
                        case (step)
                            2'd0: scl <= 1'b1;
                            2'd1: sda_low <= 1'b0; // stop condition, bus idle
                            default:
                            begin
                                req_done <= 1'b1;
                                state    <= E_IDLE;
                            end
                        endcase
                    end

                E_BYTE:
                begin
                    // sda moves one clk after scl fell
                    if (!half && cnt == '0)
                        sda_low <= !is_rd && (bit_cnt < 4'd8) && !shreg[7];
                    if (tick)
                    begin
                        if (!half)
                        begin
                            scl  <= 1'b1;
                            half <= 1'b1;
                        end
                        else
                        begin
                            scl     <= 1'b0;
                            half    <= 1'b0;
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd8)
                            begin
                                req_done <= 1'b1;
                                state    <= E_IDLE;
                            end
                        end
                    end
                end

                default:
                    state <= E_IDLE;
            endcase
        end
    end

    // shift register, shared by byte out and byte in
    always_ff @(posedge CLK)
    begin
        if (state == E_IDLE && req_valid)
            shreg <= req.wr_byte;
        else if (state == E_BYTE && sample && bit_cnt < 4'd8)
            shreg <= {shreg[6:0], sda_in};

        if (state == E_BYTE && is_rd && tick && half && bit_cnt == 4'd8)
            rx_byte <= shreg; // held until next read
    end

endmodule

// File: tb/eeprom_model.sv
`timescale 1ns/1ns
// behavioral two-wire EEPROM slave, 2 KB, zero write time
module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_pull,   // slave pulls the line low
    output logic proto_err
);
    import eeprom_pkg::*;

    logic [7:0] mem [0:2047];
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic       active = 1'b0;       // between START and STOP
    logic       addr_ok = 1'b0;
    logic       need_stop = 1'b0;    // data moved, only STOP may follow
    logic       ack_pending = 1'b0;
    logic       read_next = 1'b0;
    logic       reading = 1'b0;
    logic [1:0] byte_idx = 2'd0;
    logic [3:0] bit_cnt = 4'd0;
    logic [7:0] shreg = 8'h00;
    logic [7:0] tx_byte = 8'hFF;
    logic [2:0] page = 3'd0;
    logic [7:0] addr_lo = 8'h00;
    logic       pull = 1'b0;
    logic       err = 1'b0;

    assign sda_pull  = pull;
    assign proto_err = err;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[11'(i)] = 8'hFF;
    end

    task automatic violation(input string what);
        $display("EEPROM model at %0t ns: %s", $time, what);
        err = 1'b1;
    endtask

    // control, address and data bytes from the master
    task automatic take_byte();
        case (byte_idx)
            2'd0:
            begin
                if (shreg[7:4] != DEVICE_CODE)
                    violation("wrong device code in the control byte");
                if (shreg[0])
                begin
                    if (!addr_ok)
                        violation("read requested without a preceding address");
                    else if (shreg[3:1] != page)
                        violation("page bits of read and address control bytes differ");
                    tx_byte   = mem[{page, addr_lo}];
                    read_next = 1'b1;
                end
                else
                    page = shreg[3:1];
                byte_idx = 2'd1;
            end
            2'd1:
            begin
                addr_lo  = shreg;
                addr_ok  = 1'b1;
                byte_idx = 2'd2;
            end
            2'd2:
            begin
                mem[{page, addr_lo}] = shreg;
                need_stop = 1'b1;
                byte_idx  = 2'd3;
            end
            default:
                violation("more than one data byte written in one operation");
        endcase
        ack_pending = 1'b1;
    endtask

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            // START or STOP, legal only on the first clock of a byte
            if (active && bit_cnt != 4'd1)
                violation("SDA changed while SCL was high in the middle of a byte");
            if (sda === 1'b0)
            begin
                if (need_stop)
                    violation("START arrived before the STOP of the previous operation");
                active   = 1'b1;
                byte_idx = 2'd0;
            end
            else
            begin
                active    = 1'b0;
                addr_ok   = 1'b0;
                need_stop = 1'b0;
            end
            bit_cnt     = 4'd0;
            reading     = 1'b0;
            read_next   = 1'b0;
            ack_pending = 1'b0;
            pull        = 1'b0;
        end
        else if (scl === 1'b1 && scl_q !== 1'b1 && active)
        begin
            if (bit_cnt < 4'd8)
            begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 4'd1;
                if (reading)
                    tx_byte = {tx_byte[6:0], 1'b1};
                else if (bit_cnt == 4'd8)
                    take_byte();
            end
            else
            begin
                // ninth clock
                if (reading)
                begin
                    if (sda !== 1'b1)
                        violation("master acknowledged the read byte instead of a NACK");
                    reading   = 1'b0;
                    need_stop = 1'b1;
                end
                else if (read_next)
                begin
                    reading   = 1'b1;
                    read_next = 1'b0;
                end
                ack_pending = 1'b0;
                bit_cnt     = 4'd0;
            end
        end
        else if (scl !== 1'b1 && scl_q === 1'b1 && active)
        begin
            if (ack_pending)
                pull = 1'b1;
            else if (reading && bit_cnt < 4'd8)
                pull = !tx_byte[7];
            else
                pull = 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: tb/eeprom_tb.sv
`timescale 1ns/1ns
module eeprom_tb;
    import eeprom_pkg::*;

    localparam int N_RANDOM   = 200;
    localparam int MAX_CYCLES = 100000; // about 400 cycles per read, 200+ ops, margin

    logic         CLK = 1'b0;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    logic [7:0]   wr_data;
    logic [7:0]   rd_data;
    logic         ack;
    logic         busy;
    logic         scl;
    logic         sda_low;
    logic         sda;
    logic         model_pull;
    logic         model_err;

    logic [7:0]   shadow [0:2047];
    logic [31:0]  rnd;
    int           cycles = 0;
    int           ops_issued = 0;
    int           acks_seen = 0;
    logic         ack_q = 1'b0;
    logic         cur_read = 1'b0;
    eeprom_addr_t cur_addr = '0;

    always #20 CLK = ~CLK;

    assign sda = !(sda_low || model_pull); // pulled up unless someone pulls low

    eeprom_top dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    eeprom_model model0 (
        .scl       (scl),
        .sda       (sda),
        .sda_pull  (model_pull),
        .proto_err (model_err)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected read byte, shadow of every accepted write
    function automatic logic [7:0] expected_byte(input eeprom_addr_t a);
        return shadow[a];
    endfunction

    // half the time a small set in every page, so reads hit written bytes
    function automatic eeprom_addr_t pick_addr(input logic [31:0] r);
        if (r[3])
            return r[31:21];
        return {r[31:29], 4'h0, r[28:25]};
    endfunction

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic issue_strobe(input logic is_write, input eeprom_addr_t a,
                                input logic [7:0] d);
        @(posedge CLK);
        wr       <= is_write;
        rd       <= !is_write;
        addr     <= a;
        wr_data  <= d;
        cur_read <= !is_write;
        cur_addr <= a;
        if (is_write)
            shadow[a] = d;
        @(posedge CLK);
        wr         <= 1'b0;
        rd         <= 1'b0;
        ops_issued <= ops_issued + 1;
    endtask

    task automatic wait_for_ack();
        do
            @(negedge CLK);
        while (!ack);
    endtask

    task automatic run_op(input logic is_write, input eeprom_addr_t a, input logic [7:0] d);
        issue_strobe(is_write, a, d);
        wait_for_ack();
    endtask

    // second wr strobe lands mid operation and must be dropped
    task automatic write_with_ignored_strobe(input eeprom_addr_t a, input logic [7:0] d,
                                             input eeprom_addr_t a2, input logic [7:0] d2);
        issue_strobe(1'b1, a, d);
        repeat (20) @(posedge CLK);
        wr      <= 1'b1;
        addr    <= a2;
        wr_data <= d2;
        @(negedge CLK);
        assert (busy)
        else
        begin
            $display("DUT was not busy when the extra strobe was sampled");
            stop_with_failure();
        end
        @(posedge CLK);
        wr <= 1'b0;
        wait_for_ack();
    endtask

    // compares responses against the reference
    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            assert (model_err == 1'b0)
            else
            begin
                $display("bus protocol violation seen by the EEPROM model");
                stop_with_failure();
            end
            assert (!(ack && ack_q))
            else
            begin
                $display("ack stayed high for more than one cycle");
                stop_with_failure();
            end
            if (ack)
            begin
                assert (ops_issued == acks_seen + 1)
                else
                begin
                    $display("ack arrived without an operation in flight");
                    stop_with_failure();
                end
                assert (busy == 1'b0)
                else
                begin
                    $display("FAILED busy in ack cycle: got %h expected %h", busy, 1'b0);
                    stop_with_failure();
                end
                if (cur_read)
                    assert (rd_data == expected_byte(cur_addr))
                    else
                    begin
                        $display("FAILED rd_data at addr %h: got %h expected %h",
                                 cur_addr, rd_data, expected_byte(cur_addr));
                        stop_with_failure();
                    end
                acks_seen = acks_seen + 1;
            end
            else
                assert (busy == (ops_issued != acks_seen))
                else
                begin
                    $display("FAILED busy: got %h expected %h", busy, ops_issued != acks_seen);
                    stop_with_failure();
                end
            ack_q <= ack;
        end
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    initial
    begin
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = 8'h00;
        rnd     = 32'h2fa4;
        for (int i = 0; i < 2048; i++)
            shadow[11'(i)] = 8'hFF;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;

        repeat (5)
        begin
            @(negedge CLK);
            assert (scl == 1'b1 && sda_low == 1'b0)
            else
            begin
                $display("FAILED scl/sda_low after reset: got %h/%h expected 1/0", scl, sda_low);
                stop_with_failure();
            end
        end

        run_op(1'b1, 11'h7FF, 8'hA5); // top page bits all set
        run_op(1'b0, 11'h7FF, 8'h00);

        write_with_ignored_strobe(11'h155, 8'h3C, 11'h2AA, 8'hC3);
        run_op(1'b0, 11'h2AA, 8'h00);
        run_op(1'b0, 11'h155, 8'h00);

        for (int n = 0; n < N_RANDOM; n++)
        begin
            rnd = lcg_next(rnd);
            run_op(rnd[16], pick_addr(rnd), rnd[15:8]);
        end

        repeat (10) @(negedge CLK);
        if (ops_issued == acks_seen && !busy)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("operations and acks differ: %0d issued, %0d acked", ops_issued, acks_seen);
            stop_with_failure();
        end
    end

endmodule

// File: vlog.f
common/eeprom_pkg.sv
serial_bus/serial_bus_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_top.sv
tb/eeprom_model.sv
tb/eeprom_tb.sv
